// File: sources.f
+incdir+hw
hw/pciPkg.sv
hw/targetDecode.sv
hw/pciTargetCtrl.sv
hw/targetMemory.sv
hw/parityUnit.sv
hw/pciTarget.sv
verif/tbPciTarget.sv

// File: run.sh
#!/bin/sh
# build and run the PCI target testbench with Verilator
verilator --binary --timing -Wno-fatal -f sources.f --top-module tbPciTarget -o simv \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1 && grep -q "sim passed" sim.log \
    && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: verif/tbPciTarget.sv
//////////////////////////////
// PCI target testbench
//////////////////////////////
`timescale 1ns/1ns
`include "pci_macros.svh"

module tbPciTarget;
    import pciPkg::*;

    localparam int NUM_TRANS   = 300;
    // 300 transactions at up to about 20 cycles each, plus margin
    localparam int CYCLE_LIMIT = 8000;

    logic    CLK;
    logic    REST;
    logic    frameN;
    logic    irdyN;
    adWord_t adIn;
    cbe_t    cbe;
    logic    parIn;
    logic    devselN;
    logic    trdyN;
    logic    stopN;
    adWord_t adOut;
    logic    adOe;
    logic    parOut;
    logic    parOe;
    logic    perrN;

    integer   seed;
    int       errors;
    int       checks;
    int       cycles;
    // reference copy of the target memory
    adWord_t  model [`PCI_WIN_WORDS];
    wordIdx_t modelIdx;
    // kind of the running transaction
    logic     curRead;
    logic     curWrite;
    logic     curMiss;
    logic     curOff;
    int       xferCount;
    // read data phases not yet closed by the last or the disconnect transfer
    logic     readOpen;
    // values seen in the previous cycle
    logic     obsTrdyN;
    logic     obsAdOe;
    adWord_t  obsAdOut;
    // bad write parity waiting for its perrN pulse
    logic     perrPend;

    pciTarget u_pciTarget (
        .CLK     (CLK),
        .REST    (REST),
        .frameN  (frameN),
        .irdyN   (irdyN),
        .adIn    (adIn),
        .cbe     (cbe),
        .parIn   (parIn),
        .devselN (devselN),
        .trdyN   (trdyN),
        .stopN   (stopN),
        .adOut   (adOut),
        .adOe    (adOe),
        .parOut  (parOut),
        .parOe   (parOe),
        .perrN   (perrN)
    );

    always #4 CLK = ~CLK;

    // run limit
    always @(posedge CLK) begin
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int randBelow(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic isReadCmd(input cbe_t c);
        return (c == `PCI_CMD_MEM_READ) || (c == `PCI_CMD_READ_MULT) ||
               (c == `PCI_CMD_READ_LINE);
    endfunction

    function automatic logic isWriteCmd(input cbe_t c);
        return (c == `PCI_CMD_MEM_WRITE) || (c == `PCI_CMD_WRITE_INV);
    endfunction

    task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("mismatch %s expected %h actual %h at cycle %0d", name, exp, act, cycles);
        end
    endtask

    task automatic driveBus(input logic f, input logic i, input adWord_t a, input cbe_t c);
        frameN = f;
        irdyN  = i;
        adIn   = a;
        cbe    = c;
    endtask

    // one clock, then model update and per cycle checks
    task automatic stepCycle();
        logic    xferNow;
        logic    badPar;
        logic    expPerrLow;
        adWord_t expWord;
        xferNow = !irdyN && !obsTrdyN;
        expWord = model[modelIdx];
        @(posedge CLK);
        #1;
        cycles++;
        expPerrLow = perrPend;
        perrPend   = 1'b0;
        parIn      = $random(seed);
        // master parity for a write goes out one cycle after the transfer
        if (xferNow && curWrite) begin
            badPar   = (randBelow(8) == 0);
            parIn    = (^{adIn, cbe}) ^ badPar;
            perrPend = badPar;
            for (int b = 0; b < 4; b++) begin
                if (cbe[b]) begin
                    model[modelIdx][8*b +: 8] = adIn[8*b +: 8];
                end
            end
        end
        if (xferNow && curRead) begin
            checkEq("read data", expWord, obsAdOut);
            checkEq("read adOe", 32'd1, 32'(obsAdOe));
            checkEq("read parOe", 32'd1, 32'(parOe));
            checkEq("read parity", 32'(^{expWord, cbe}), 32'(parOut));
        end else begin
            checkEq("parOe idle", 32'd0, 32'(parOe));
        end
        if (xferNow) begin
            // wraps after word 3
            modelIdx = modelIdx + 1'b1;
            xferCount++;
            // last data phase or disconnect, ad released next cycle
            if (frameN || curOff) begin
                readOpen = 1'b0;
            end
        end
        checkEq("perrN", 32'(!expPerrLow), 32'(perrN));
        checkEq("adOe", 32'(curRead && readOpen), 32'(adOe));
        if (curMiss) begin
            checkEq("miss outputs", 32'h7, 32'({devselN, trdyN, stopN}));
        end
        obsTrdyN = trdyN;
        obsAdOut = adOut;
        obsAdOe  = adOe;
    endtask

    // one bus transaction from the master side
    task automatic runTransaction(input cbe_t cmd, input adWord_t addr, input int len,
                                  input logic fullBe);
        adWord_t data [4];
        cbe_t    be [4];
        logic    hit;
        logic    unsup;
        logic    offStart;
        logic    stopSeen;
        logic    done;
        logic    last;
        logic    moved;
        logic    frameLow;
        logic    justMoved;
        int      phase;
        int      waitLeft;
        int      cyc;
        int      prevCount;
        hit      = (addr >= `PCI_BASE_ADDR) && (addr < `PCI_BASE_ADDR + 4 * `PCI_WIN_WORDS);
        unsup    = !(isReadCmd(cmd) || isWriteCmd(cmd));
        offStart = hit && !unsup && (addr[3:2] != 2'd0);
        for (int i = 0; i < 4; i++) begin
            data[i] = $random(seed);
            be[i]   = fullBe ? 4'hF : cbe_t'($random(seed));
        end
        curRead   = hit && isReadCmd(cmd);
        curWrite  = hit && isWriteCmd(cmd);
        curMiss   = !hit;
        curOff    = offStart;
        readOpen  = 1'b0;
        modelIdx  = addr[3:2];
        xferCount = 0;

        // address phase
        driveBus(1'b0, 1'b1, addr, cmd);
        stepCycle();
        checkEq("decode devselN", 32'(!hit), 32'(devselN));
        if (hit && unsup) begin
            checkEq("retry stop", 32'b01, 32'({stopN, trdyN}));
        end
        // a read drives ad from the cycle after the turnaround
        readOpen = curRead;

        phase     = 0;
        stopSeen  = 1'b0;
        done      = 1'b0;
        justMoved = 1'b0;
        frameLow  = 1'b0;
        cyc       = 1;
        waitLeft  = randBelow(3);
        while (!done) begin
            if (!stopN) begin
                stopSeen = 1'b1;
            end
            // after the single disconnect transfer trdy drops out, stop holds
            if (offStart && justMoved && frameLow) begin
                checkEq("disconnect", 32'b10, 32'({trdyN, stopN}));
            end
            prevCount = xferCount;
            frameLow  = 1'b0;
            if (!stopN && trdyN) begin
                // retry or end of disconnect, close the frame
                driveBus(1'b1, 1'b0, data[phase], be[phase]);
                stepCycle();
                done = 1'b1;
            end else if (!hit && cyc >= 4) begin
                // nobody claimed it, master abort
                driveBus(1'b1, 1'b0, '0, '0);
                stepCycle();
                done = 1'b1;
            end else if (waitLeft > 0 && !stopSeen) begin
                driveBus(1'b0, 1'b1, data[phase], be[phase]);
                waitLeft--;
                stepCycle();
            end else begin
                // stop comes with trdy, so the phase in flight completes as planned
                last     = (phase == len - 1);
                moved    = !trdyN;
                frameLow = !last;
                driveBus(last, 1'b0, data[phase], be[phase]);
                stepCycle();
                if (moved) begin
                    phase++;
                    waitLeft = randBelow(3);
                    done     = last;
                end
            end
            justMoved = (xferCount > prevCount);
            cyc++;
        end

        if (hit && unsup) begin
            checkEq("retry transfers", 32'd0, 32'(xferCount));
        end else if (offStart) begin
            checkEq("disconnect transfers", 32'd1, 32'(xferCount));
        end else if (hit) begin
            checkEq("burst transfers", 32'(len), 32'(xferCount));
        end else begin
            checkEq("miss transfers", 32'd0, 32'(xferCount));
        end

        // bus idle between transactions
        driveBus(1'b1, 1'b1, '0, '0);
        stepCycle();
        repeat (randBelow(2)) begin
            stepCycle();
        end
    endtask

    initial begin
        cbe_t    cmd;
        adWord_t addr;
        seed      = 93294;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        CLK       = 1'b0;
        REST      = 1'b0;
        frameN    = 1'b1;
        irdyN     = 1'b1;
        adIn      = '0;
        cbe       = '0;
        parIn     = 1'b0;
        modelIdx  = '0;
        curRead   = 1'b0;
        curWrite  = 1'b0;
        curMiss   = 1'b0;
        curOff    = 1'b0;
        readOpen  = 1'b0;
        xferCount = 0;
        obsTrdyN  = 1'b1;
        obsAdOe   = 1'b0;
        obsAdOut  = '0;
        perrPend  = 1'b0;

        repeat (4) @(posedge CLK);
        #1;
        REST = 1'b1;
        stepCycle();
        stepCycle();

        // fill every word so later reads have a known value
        runTransaction(`PCI_CMD_MEM_WRITE, `PCI_BASE_ADDR, 4, 1'b1);

        for (int t = 0; t < NUM_TRANS; t++) begin
            case (randBelow(8))
                0: cmd = `PCI_CMD_MEM_READ;
                1: cmd = `PCI_CMD_MEM_WRITE;
                2: cmd = `PCI_CMD_READ_MULT;
                3: cmd = `PCI_CMD_READ_LINE;
                4: cmd = `PCI_CMD_WRITE_INV;
                5: cmd = `PCI_CMD_MEM_WRITE;
                // I/O read, not served here
                6: cmd = 4'b0010;
                default: cmd = cbe_t'($random(seed));
            endcase
            case (randBelow(4))
                0, 1: addr = `PCI_BASE_ADDR + 4 * randBelow(4);
                // one word past the window
                2: addr = `PCI_BASE_ADDR + 4 * `PCI_WIN_WORDS;
                default: addr = $random(seed);
            endcase
            runTransaction(cmd, addr, 1 + randBelow(4), 1'b0);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: hw/pciTarget.sv
//////////////////////////////
// PCI memory target
//////////////////////////////
`timescale 1ns/1ns

module pciTarget (
    input  logic            CLK,
    input  logic            REST,
    input  logic            frameN,
    input  logic            irdyN,
    input  pciPkg::adWord_t adIn,
    input  pciPkg::cbe_t    cbe,
    input  logic            parIn,
    output logic            devselN,
    output logic            trdyN,
    output logic            stopN,
    output pciPkg::adWord_t adOut,
    output logic            adOe,
    output logic            parOut,
    output logic            parOe,
    output logic            perrN
);
    import pciPkg::*;

    decodeInfo_t decode;
    xferCtl_t    xfer;
    logic        addrStart;

    // address and command latch
    targetDecode u_targetDecode (
        .CLK       (CLK),
        .REST      (REST),
        .frameN    (frameN),
        .adIn      (adIn),
        .cbe       (cbe),
        .addrStart (addrStart),
        .decode    (decode)
    );

    // bus handshake
    pciTargetCtrl u_pciTargetCtrl (
        .CLK       (CLK),
        .REST      (REST),
        .frameN    (frameN),
        .irdyN     (irdyN),
        .decode    (decode),
        .addrStart (addrStart),
        .xfer      (xfer),
        .devselN   (devselN),
        .trdyN     (trdyN),
        .stopN     (stopN)
    );

    // storage, read word doubles as the ad output value
    targetMemory u_targetMemory (
        .CLK      (CLK),
        .REST     (REST),
        .decode   (decode),
        .xfer     (xfer),
        .adIn     (adIn),
        .cbe      (cbe),
        .readWord (adOut)
    );

    parityUnit u_parityUnit (
        .CLK      (CLK),
        .REST     (REST),
        .xfer     (xfer),
        .adIn     (adIn),
        .readWord (adOut),
        .cbe      (cbe),
        .parIn    (parIn),
        .parOut   (parOut),
        .parOe    (parOe),
        .perrN    (perrN)
    );

    // ad enable comes from the controller strobes
    assign adOe = xfer.adDrive;

endmodule

// File: hw/parityUnit.sv
//////////////////////////////
// data parity
//////////////////////////////
`timescale 1ns/1ns

module parityUnit (
    input  logic             CLK,
    input  logic             REST,
    input  pciPkg::xferCtl_t xfer,
    input  pciPkg::adWord_t  adIn,
    input  pciPkg::adWord_t  readWord,
    input  pciPkg::cbe_t     cbe,
    input  logic             parIn,
    output logic             parOut,
    output logic             parOe,
    output logic             perrN
);

    logic wrPar;
    logic chkPend;

    // even parity over ad and cbe
    // read side is driven by the target, write side by the master
    always_ff @(posedge CLK) begin
        if (xfer.rdXfer) begin
            parOut <= ^{readWord, cbe};
        end
        if (xfer.wrXfer) begin
            wrPar <= ^{adIn, cbe};
        end
    end

    always_ff @(posedge CLK or negedge REST) begin
        if (!REST) begin
            parOe   <= 1'b0;
            chkPend <= 1'b0;
            perrN   <= 1'b1;
        end else begin
            // par follows its data by one cycle
            parOe   <= xfer.rdXfer;
            // master parity arrives one cycle after the write transfer
            chkPend <= xfer.wrXfer;
            // one cycle pulse per bad data phase
            perrN   <= !(chkPend && (parIn != wrPar));
        end
    end

endmodule

// File: hw/targetMemory.sv
//////////////////////////////
// four word target memory
//////////////////////////////
`timescale 1ns/1ns
`include "pci_macros.svh"

module targetMemory (
    input  logic                CLK,
    input  logic                REST,
    input  pciPkg::decodeInfo_t decode,
    input  pciPkg::xferCtl_t    xfer,
    input  pciPkg::adWord_t     adIn,
    input  pciPkg::cbe_t        cbe,
    output pciPkg::adWord_t     readWord
);
    import pciPkg::*;

    adWord_t  mem [`PCI_WIN_WORDS];
    wordIdx_t idx;

    // burst pointer
    // loads in the address phase, steps on every transfer
    always_ff @(posedge CLK or negedge REST) begin
        if (!REST) begin
            idx <= '0;
        end else if (xfer.loadIdx) begin
            idx <= decode.startIdx;
        end else if (xfer.wrXfer || xfer.rdXfer) begin
            // two bit index wraps after word 3
            idx <= idx + 1'b1;
        end
    end

    // byte masked write at the current index
    always_ff @(posedge CLK) begin
        if (xfer.wrXfer) begin
            for (int b = 0; b < `PCI_CBE_W; b++) begin
                // disabled bytes keep their old value
                if (cbe[b]) begin
                    mem[idx][8*b +: 8] <= adIn[8*b +: 8];
                end
            end
        end
    end

    // word at the pointer goes straight to the bus
    assign readWord = mem[idx];

endmodule

// File: hw/pciTargetCtrl.sv
//////////////////////////////
// target controller FSM
//////////////////////////////
`timescale 1ns/1ns

module pciTargetCtrl (
    input  logic                CLK,
    input  logic                REST,
    input  logic                frameN,
    input  logic                irdyN,
    input  pciPkg::decodeInfo_t decode,
    output logic                addrStart,
    output pciPkg::xferCtl_t    xfer,
    output logic                devselN,
    output logic                trdyN,
    output logic                stopN
);
    import pciPkg::*;

    ctrlState_t state;
    ctrlState_t stateNext;
    logic       devselNext;
    logic       trdyNext;
    logic       stopNext;
    logic       driveNext;
    logic       adDrive;
    logic       inData;
    logic       dataXfer;

    // first frame cycle seen from idle is the address phase
    assign addrStart = (state == idle) && !frameN;

    // transfer needs both ready lines low in a data state
    assign inData   = (state == writeData) || (state == readData);
    assign dataXfer = inData && !irdyN && !trdyN;

    always_comb begin
        xfer.loadIdx = addrStart && decode.hit;
        xfer.wrXfer  = dataXfer && (state == writeData);
        xfer.rdXfer  = dataXfer && (state == readData);
        xfer.adDrive = adDrive;
    end

    always_comb begin
        stateNext  = state;
        // outputs rest deasserted unless a state claims them
        devselNext = 1'b1;
        trdyNext   = 1'b1;
        stopNext   = 1'b1;
        driveNext  = 1'b0;
        case (state)
            idle: begin
                if (addrStart) begin
                    if (!decode.hit) begin
                        stateNext = otherBusy;
                    end else if (decode.unsupported) begin
                        // retry, no data
                        stateNext  = stopWait;
                        devselNext = 1'b0;
                        stopNext   = 1'b0;
                    end else if (decode.isWrite) begin
                        stateNext  = writeData;
                        devselNext = 1'b0;
                        trdyNext   = 1'b0;
                        stopNext   = !decode.offStart;
                    end else if (decode.isRead) begin
                        // reads need a turnaround cycle on ad
                        stateNext  = readTurn;
                        devselNext = 1'b0;
                    end
                end
            end
            otherBusy: begin
                // someone else's transaction, wait for bus idle
                if (frameN && irdyN) begin
                    stateNext = idle;
                end
            end
            readTurn: begin
                stateNext  = readData;
                devselNext = 1'b0;
                trdyNext   = 1'b0;
                stopNext   = !decode.offStart;
                driveNext  = 1'b1;
            end
            writeData, readData: begin
                if ((dataXfer && frameN) || (frameN && irdyN)) begin
                    // final transfer, release everything next cycle
                    stateNext = idle;
                end else if (dataXfer && decode.offStart) begin
                    // disconnect with data after one word
                    stateNext  = stopWait;
                    devselNext = 1'b0;
                    stopNext   = 1'b0;
                end else begin
                    // hold through irdy wait states
                    devselNext = 1'b0;
                    trdyNext   = 1'b0;
                    stopNext   = !decode.offStart;
                    driveNext  = (state == readData);
                end
            end
            stopWait: begin
                // keep stop until the master drops frame
                if (frameN) begin
                    stateNext = idle;
                end else begin
                    devselNext = 1'b0;
                    stopNext   = 1'b0;
                end
            end
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge CLK or negedge REST) begin
        if (!REST) begin
            state   <= idle;
            devselN <= 1'b1;
            trdyN   <= 1'b1;
            stopN   <= 1'b1;
            adDrive <= 1'b0;
        end else begin
            state   <= stateNext;
            devselN <= devselNext;
            trdyN   <= trdyNext;
            stopN   <= stopNext;
            adDrive <= driveNext;
        end
    end

endmodule

// File: hw/targetDecode.sv
//////////////////////////////
// address phase decode
//////////////////////////////
`timescale 1ns/1ns
`include "pci_macros.svh"

module targetDecode (
    input  logic                CLK,
    input  logic                REST,
    input  logic                frameN,
    input  pciPkg::adWord_t     adIn,
    input  pciPkg::cbe_t        cbe,
    input  logic                addrStart,
    output pciPkg::decodeInfo_t decode
);
    import pciPkg::*;

    decodeInfo_t decodeNow;
    decodeInfo_t decodeReg;
    adWord_t     offset;
    logic        cmdRead;
    logic        cmdWrite;

    // byte offset of the address from the window base
    assign offset = adIn - `PCI_BASE_ADDR;

    // read family: memory read, read multiple, read line
    assign cmdRead = (cbe == `PCI_CMD_MEM_READ) ||
                     (cbe == `PCI_CMD_READ_MULT) ||
                     (cbe == `PCI_CMD_READ_LINE);
    // write family
    assign cmdWrite = (cbe == `PCI_CMD_MEM_WRITE) ||
                      (cbe == `PCI_CMD_WRITE_INV);

    always_comb begin
        // address only counts while frame is asserted
        // addresses below the base wrap to a large offset and miss
        decodeNow.hit         = !frameN &&
                                (offset[`PCI_AD_W-1:2] < (`PCI_AD_W-2)'(`PCI_WIN_WORDS));
        decodeNow.isRead      = cmdRead;
        decodeNow.isWrite     = cmdWrite;
        decodeNow.unsupported = !(cmdRead || cmdWrite);
        // low two address bits carry burst order, ignored
        decodeNow.startIdx    = offset[`PCI_IDX_W+1:2];
        decodeNow.offStart    = (offset[`PCI_IDX_W+1:2] != '0);
    end

    // hold the decode for the rest of the transaction
    always_ff @(posedge CLK or negedge REST) begin
        if (!REST) begin
            decodeReg <= '0;
        end else if (addrStart) begin
            decodeReg <= decodeNow;
        end
    end

    // live decode in the address phase so the FSM can claim fast
    assign decode = addrStart ? decodeNow : decodeReg;

endmodule

// File: hw/pciPkg.sv
//////////////////////////////
// PCI target types
//////////////////////////////
`include "pci_macros.svh"

package pciPkg;

    // one address or data word
    typedef logic [`PCI_AD_W-1:0] adWord_t;
    // command in the address phase, byte enables after it (1 = byte on)
    typedef logic [`PCI_CBE_W-1:0] cbe_t;
    // index into the four word memory
    typedef logic [`PCI_IDX_W-1:0] wordIdx_t;

    // controller states
    typedef enum logic [2:0] {
        idle,
        otherBusy,
        writeData,
        readTurn,
        readData,
        stopWait
    } ctrlState_t;

    // address phase result, held for the whole transaction
    typedef struct packed {
        logic     hit;
        logic     isRead;
        logic     isWrite;
        logic     unsupported;
        // start word is not word 0
        logic     offStart;
        wordIdx_t startIdx;
    } decodeInfo_t;

    // per cycle strobes from the controller to the datapath
    typedef struct packed {
        logic loadIdx;
        logic wrXfer;
        logic rdXfer;
        logic adDrive;
    } xferCtl_t;

endpackage

// File: hw/pci_macros.svh
//////////////////////////////
// PCI target constants
//////////////////////////////
`ifndef PCI_MACROS_SVH
`define PCI_MACROS_SVH

// decoded memory window, four words from the base
`define PCI_BASE_ADDR 32'hFFFF_0000
`define PCI_WIN_WORDS 4

// bus field widths
`define PCI_AD_W  32
`define PCI_CBE_W 4
`define PCI_IDX_W 2

// command codes seen on cbe in the address phase
`define PCI_CMD_MEM_READ  4'b0110
`define PCI_CMD_MEM_WRITE 4'b0111
`define PCI_CMD_READ_MULT 4'b1100
`define PCI_CMD_READ_LINE 4'b1110
// write and invalidate behaves as a plain write here
`define PCI_CMD_WRITE_INV 4'b1111

`endif
